/* hdl/dma_wr_pkg.sv */
// ----------------------------------------------------------
// widths and payload types shared by the DMA write engine
// ----------------------------------------------------------

package dma_wr_pkg;

    // AXI address and data widths
    localparam int ADDR_W = 32;
    localparam int DATA_W = 32;
    localparam int LEN_W  = 8;

    // ring size and credit counts, in beats
    localparam int SIZE_W = 16;
    localparam int TMO_W  = 8;

    // byte step of one beat
    localparam int BEAT_BYTES = DATA_W / 8;

    typedef logic [DATA_W-1:0] beat_t;
    typedef logic [LEN_W-1:0]  len_t;
    typedef logic [SIZE_W-1:0] size_t;
    typedef logic [ADDR_W-1:0] addr_t;

endpackage

/* hdl/dma_wr_cmd_if.sv */
// ----------------------------------------------------------
// burst command channel, ring offset and length
// ----------------------------------------------------------

`timescale 1ns/1ps

interface dma_wr_cmd_if;

    dma_wr_pkg::addr_t addr;
    dma_wr_pkg::len_t  len;
    logic              valid;
    logic              ready;

    // addr and len hold while valid waits for ready
    modport src (output addr, output len, output valid, input ready);
    modport dst (input addr, input len, input valid, output ready);

endinterface

/* hdl/dma_wr_fifo.sv */
// ----------------------------------------------------------
// synchronous first-word-fall-through FIFO
// ----------------------------------------------------------

`timescale 1ns/1ps

module dma_wr_fifo import dma_wr_pkg::*; #(
    parameter type payload_t  = beat_t,
    parameter int  DEPTH_LOG2 = 4
) (
    input  logic     aclk,
    input  logic     aresetn,
    input  payload_t i_data,
    input  logic     i_valid,
    output logic     o_ready,
    output payload_t o_data,
    output logic     o_valid,
    input  logic     i_ready
);

    localparam int DEPTH = 1 << DEPTH_LOG2;

    payload_t              mem [DEPTH];
    logic [DEPTH_LOG2-1:0] wr_ptr;
    logic [DEPTH_LOG2-1:0] rd_ptr;
    logic [DEPTH_LOG2:0]   count;
    logic [DEPTH_LOG2:0]   count_nxt;
    logic                  wr_en;
    logic                  rd_en;

    assign wr_en     = i_valid && o_ready;
    assign rd_en     = o_valid && i_ready;
    assign count_nxt = count + wr_en - rd_en;
    assign o_valid   = (count != '0);
    assign o_data    = mem[rd_ptr];

    always_ff @(posedge aclk) begin
        if (!aresetn) begin
            wr_ptr  <= '0;
            rd_ptr  <= '0;
            count   <= '0;
            o_ready <= 1'b0;
        end else begin
            wr_ptr  <= wr_ptr + wr_en;
            rd_ptr  <= rd_ptr + rd_en;
            count   <= count_nxt;
            // registered not-full flag
            o_ready <= (count_nxt != DEPTH[DEPTH_LOG2:0]);
        end
    end

    always_ff @(posedge aclk) begin
        if (wr_en) begin
            mem[wr_ptr] <= i_data;
        end
    end

    a_no_write_full: assert property (@(posedge aclk) disable iff (!aresetn)
        (count == DEPTH[DEPTH_LOG2:0]) |-> !wr_en);

endmodule

/* hdl/dma_wr_regs.sv */
// ----------------------------------------------------------
// configuration registers and outstanding-beat busy tracking
// ----------------------------------------------------------

`timescale 1ns/1ps

module dma_wr_regs import dma_wr_pkg::*; (
    input  logic               aclk,
    input  logic               aresetn,
    input  logic               i_enable,
    input  logic               i_update_param,
    input  addr_t              i_base,
    input  size_t              i_ring_size,
    input  len_t               i_max_len,
    input  logic [TMO_W-1:0]   i_timeout,
    input  logic [DATA_W/8-1:0] i_wstrb,
    input  logic               i_issued_valid,
    input  len_t               i_issued_len,
    input  logic               i_done_valid,
    input  len_t               i_done_len,
    output addr_t              o_base,
    output size_t              o_ring_size,
    output len_t               o_max_len,
    output logic [TMO_W-1:0]   o_timeout,
    output logic [DATA_W/8-1:0] o_wstrb,
    output logic               o_busy,
    output logic               o_reload
);

    size_t outstanding;
    size_t issued_beats;
    size_t done_beats;
    logic  load;

    // lengths are beats minus one
    assign issued_beats = i_issued_valid ? size_t'(i_issued_len) + size_t'(1) : '0;
    assign done_beats   = i_done_valid ? size_t'(i_done_len) + size_t'(1) : '0;

    assign o_busy = i_enable || (outstanding != '0);
    assign load   = i_update_param && !o_busy;

    always_ff @(posedge aclk) begin
        if (!aresetn) begin
            o_base      <= '0;
            o_ring_size <= '0;
            o_max_len   <= '0;
            o_timeout   <= '0;
            o_wstrb     <= '0;
            o_reload    <= 1'b0;
            outstanding <= '0;
        end else begin
            o_reload    <= load;
            outstanding <= outstanding + issued_beats - done_beats;
            if (load) begin
                o_base      <= i_base;
                o_ring_size <= i_ring_size;
                o_max_len   <= i_max_len;
                o_timeout   <= i_timeout;
                o_wstrb     <= i_wstrb;
            end
        end
    end

endmodule

/* hdl/dma_wr_burst_ctrl.sv */
// ----------------------------------------------------------
// credit, pending beats and timeout batching into bursts
// ----------------------------------------------------------

`timescale 1ns/1ps

module dma_wr_burst_ctrl import dma_wr_pkg::*; (
    input  logic             aclk,
    input  logic             aresetn,
    input  logic             i_enable,
    input  logic             i_reload,
    input  size_t            i_ring_size,
    input  len_t             i_max_len,
    input  logic [TMO_W-1:0] i_timeout,
    input  logic             i_beat_in,
    input  len_t             i_permit_size,
    input  logic             i_permit_valid,
    dma_wr_cmd_if.src        cmd
);

    size_t            credit;
    size_t            pending;
    size_t            offset;
    logic [TMO_W-1:0] timer;
    size_t            burst_max;
    size_t            to_end;
    size_t            n_beats;
    size_t            permit_add;
    size_t            issue_sub;
    logic [SIZE_W:0]  credit_sum;
    logic             trigger;
    logic             issue;

    // burst length is the smallest of the four limits
    always_comb begin
        burst_max = size_t'(i_max_len) + size_t'(1);
        to_end    = i_ring_size - offset;
        n_beats   = pending;
        if (credit < n_beats) begin
            n_beats = credit;
        end
        if (burst_max < n_beats) begin
            n_beats = burst_max;
        end
        if (to_end < n_beats) begin
            n_beats = to_end;
        end
    end

    assign trigger = (pending >= burst_max) || ((pending != '0) && (timer >= i_timeout));
    // n_beats is zero whenever credit or pending is
    assign issue   = trigger && (n_beats != '0) && i_enable && !cmd.valid;

    assign permit_add = i_permit_valid ? size_t'(i_permit_size) + size_t'(1) : '0;
    assign issue_sub  = issue ? n_beats : '0;
    assign credit_sum = {1'b0, credit} + {1'b0, permit_add} - {1'b0, issue_sub};

    always_ff @(posedge aclk) begin
        if (!aresetn) begin
            credit    <= '0;
            pending   <= '0;
            offset    <= '0;
            timer     <= '0;
            cmd.valid <= 1'b0;
        end else begin
            pending <= pending + size_t'(i_beat_in) - issue_sub;
            if (i_reload) begin
                credit <= i_ring_size;
                offset <= '0;
            end else begin
                credit <= credit_sum[SIZE_W-1:0];
                if (issue) begin
                    offset <= (n_beats == to_end) ? '0 : offset + n_beats;
                end
            end
            // timer runs only while beats wait
            if (issue || (pending == '0)) begin
                timer <= '0;
            end else if (timer < i_timeout) begin
                timer <= timer + 1'b1;
            end
            if (issue) begin
                cmd.valid <= 1'b1;
            end else if (cmd.ready) begin
                cmd.valid <= 1'b0;
            end
        end
    end

    always_ff @(posedge aclk) begin
        if (issue) begin
            cmd.addr <= addr_t'(offset);
            cmd.len  <= len_t'(n_beats - size_t'(1));
        end
    end

    // credit must never wrap below zero
    a_credit_range: assert property (@(posedge aclk) disable iff (!aresetn)
        !i_reload |-> !credit_sum[SIZE_W]);

endmodule

/* hdl/dma_wr_addr_gen.sv */
// ----------------------------------------------------------
// base address add and three-way fork of each burst command
// ----------------------------------------------------------

`timescale 1ns/1ps

module dma_wr_addr_gen import dma_wr_pkg::*; (
    input  logic      aclk,
    input  logic      aresetn,
    input  addr_t     i_base,
    dma_wr_cmd_if.dst cmd,
    output addr_t     o_awaddr,
    output len_t      o_awlen,
    output logic      o_awvalid,
    input  logic      i_awready,
    output len_t      o_wlen,
    output logic      o_wlen_valid,
    input  logic      i_wlen_ready,
    output len_t      o_blen,
    output logic      o_blen_valid,
    input  logic      i_blen_ready
);

    // ring offset is in beats
    assign o_awaddr = i_base + cmd.addr * addr_t'(BEAT_BYTES);
    assign o_awlen  = cmd.len;
    assign o_wlen   = cmd.len;
    assign o_blen   = cmd.len;

    // each sink sees valid only when the other two can take it
    assign o_awvalid    = cmd.valid && i_wlen_ready && i_blen_ready;
    assign o_wlen_valid = cmd.valid && i_awready && i_blen_ready;
    assign o_blen_valid = cmd.valid && i_awready && i_wlen_ready;

    assign cmd.ready = i_awready && i_wlen_ready && i_blen_ready;

    // AW must hold while stalled
    a_aw_stable: assert property (@(posedge aclk) disable iff (!aresetn)
        (o_awvalid && !i_awready) |=> (o_awvalid && $stable(o_awaddr) && $stable(o_awlen)));

endmodule

/* hdl/dma_wr_beat_gate.sv */
// ----------------------------------------------------------
// W channel gating in burst-sized groups with wlast
// ----------------------------------------------------------

`timescale 1ns/1ps

module dma_wr_beat_gate import dma_wr_pkg::*; (
    input  logic  aclk,
    input  logic  aresetn,
    input  len_t  i_len,
    input  logic  i_len_valid,
    output logic  o_len_ready,
    input  beat_t i_data,
    input  logic  i_data_valid,
    output logic  o_data_ready,
    output beat_t o_wdata,
    output logic  o_wlast,
    output logic  o_wvalid,
    input  logic  i_wready
);

    len_t burst_len;
    len_t beat_cnt;
    logic active;
    logic len_go;
    logic beat_go;
    logic last_beat;

    assign o_len_ready  = !active;
    assign o_data_ready = active && (!o_wvalid || i_wready);
    assign len_go       = i_len_valid && o_len_ready;
    assign beat_go      = i_data_valid && o_data_ready;
    assign last_beat    = (beat_cnt == burst_len);

    always_ff @(posedge aclk) begin
        if (!aresetn) begin
            active   <= 1'b0;
            beat_cnt <= '0;
            o_wvalid <= 1'b0;
            o_wlast  <= 1'b0;
        end else begin
            if (len_go) begin
                active   <= 1'b1;
                beat_cnt <= '0;
            end else if (beat_go) begin
                beat_cnt <= beat_cnt + 1'b1;
                if (last_beat) begin
                    active <= 1'b0;
                end
            end
            // output stage
            if (beat_go) begin
                o_wvalid <= 1'b1;
                o_wlast  <= last_beat;
            end else if (i_wready) begin
                o_wvalid <= 1'b0;
                o_wlast  <= 1'b0;
            end
        end
    end

    always_ff @(posedge aclk) begin
        if (len_go) begin
            burst_len <= i_len;
        end
        if (beat_go) begin
            o_wdata <= i_data;
        end
    end

    // beat count stays inside the open burst
    a_cnt_in_burst: assert property (@(posedge aclk) disable iff (!aresetn)
        active |-> (beat_cnt <= burst_len));

endmodule

/* hdl/dma_wr_top.sv */
// ----------------------------------------------------------
// DMA write engine top level, AXI4 write master to a ring
// ----------------------------------------------------------

`timescale 1ns/1ps

module dma_wr_top import dma_wr_pkg::*; #(
    parameter int DATA_FIFO_DEPTH_LOG2 = 9,
    parameter int LEN_FIFO_DEPTH_LOG2  = 4
) (
    input  logic                aclk,
    input  logic                aresetn,
    input  logic                i_enable,
    output logic                o_busy,
    input  logic                i_update_param,
    input  addr_t               i_param_base,
    input  size_t               i_param_ring_size,
    input  len_t                i_param_max_len,
    input  logic [TMO_W-1:0]    i_param_timeout,
    input  logic [DATA_W/8-1:0] i_param_wstrb,
    input  beat_t               i_s_data,
    input  logic                i_s_valid,
    output logic                o_s_ready,
    input  len_t                i_permit_size,
    input  logic                i_permit_valid,
    output len_t                o_complete_size,
    output logic                o_complete_valid,
    output addr_t               o_awaddr,
    output len_t                o_awlen,
    output logic [2:0]          o_awsize,
    output logic [1:0]          o_awburst,
    output logic                o_awvalid,
    input  logic                i_awready,
    output beat_t               o_wdata,
    output logic [DATA_W/8-1:0] o_wstrb,
    output logic                o_wlast,
    output logic                o_wvalid,
    input  logic                i_wready,
    input  logic                i_bvalid,
    output logic                o_bready
);

    addr_t            base;
    size_t            ring_size;
    len_t             max_len;
    logic [TMO_W-1:0] timeout;
    logic             reload;

    beat_t fifo_data;
    logic  fifo_valid;
    logic  fifo_ready;

    len_t wlen_in;
    logic wlen_in_valid;
    logic wlen_in_ready;
    len_t wlen_out;
    logic wlen_out_valid;
    logic wlen_out_ready;

    len_t blen_in;
    logic blen_in_valid;
    logic blen_in_ready;
    len_t blen_out;
    logic blen_out_valid;

    dma_wr_cmd_if cmd_bus ();

    // AXI fixed fields
    assign o_awsize  = 3'($clog2(BEAT_BYTES));
    assign o_awburst = 2'b01;
    assign o_bready  = 1'b1;

    dma_wr_regs regs_i (
        .aclk           (aclk),
        .aresetn        (aresetn),
        .i_enable       (i_enable),
        .i_update_param (i_update_param),
        .i_base         (i_param_base),
        .i_ring_size    (i_param_ring_size),
        .i_max_len      (i_param_max_len),
        .i_timeout      (i_param_timeout),
        .i_wstrb        (i_param_wstrb),
        .i_issued_valid (cmd_bus.valid && cmd_bus.ready),
        .i_issued_len   (cmd_bus.len),
        .i_done_valid   (o_complete_valid),
        .i_done_len     (o_complete_size),
        .o_base         (base),
        .o_ring_size    (ring_size),
        .o_max_len      (max_len),
        .o_timeout      (timeout),
        .o_wstrb        (o_wstrb),
        .o_busy         (o_busy),
        .o_reload       (reload)
    );

    dma_wr_fifo #(
        .payload_t  (beat_t),
        .DEPTH_LOG2 (DATA_FIFO_DEPTH_LOG2)
    ) data_fifo_i (
        .aclk    (aclk),
        .aresetn (aresetn),
        .i_data  (i_s_data),
        .i_valid (i_s_valid),
        .o_ready (o_s_ready),
        .o_data  (fifo_data),
        .o_valid (fifo_valid),
        .i_ready (fifo_ready)
    );

    dma_wr_burst_ctrl burst_ctrl_i (
        .aclk           (aclk),
        .aresetn        (aresetn),
        .i_enable       (i_enable),
        .i_reload       (reload),
        .i_ring_size    (ring_size),
        .i_max_len      (max_len),
        .i_timeout      (timeout),
        .i_beat_in      (i_s_valid && o_s_ready),
        .i_permit_size  (i_permit_size),
        .i_permit_valid (i_permit_valid),
        .cmd            (cmd_bus.src)
    );

    dma_wr_addr_gen addr_gen_i (
        .aclk         (aclk),
        .aresetn      (aresetn),
        .i_base       (base),
        .cmd          (cmd_bus.dst),
        .o_awaddr     (o_awaddr),
        .o_awlen      (o_awlen),
        .o_awvalid    (o_awvalid),
        .i_awready    (i_awready),
        .o_wlen       (wlen_in),
        .o_wlen_valid (wlen_in_valid),
        .i_wlen_ready (wlen_in_ready),
        .o_blen       (blen_in),
        .o_blen_valid (blen_in_valid),
        .i_blen_ready (blen_in_ready)
    );

    dma_wr_fifo #(
        .payload_t  (len_t),
        .DEPTH_LOG2 (LEN_FIFO_DEPTH_LOG2)
    ) wlen_fifo_i (
        .aclk    (aclk),
        .aresetn (aresetn),
        .i_data  (wlen_in),
        .i_valid (wlen_in_valid),
        .o_ready (wlen_in_ready),
        .o_data  (wlen_out),
        .o_valid (wlen_out_valid),
        .i_ready (wlen_out_ready)
    );

    dma_wr_beat_gate beat_gate_i (
        .aclk         (aclk),
        .aresetn      (aresetn),
        .i_len        (wlen_out),
        .i_len_valid  (wlen_out_valid),
        .o_len_ready  (wlen_out_ready),
        .i_data       (fifo_data),
        .i_data_valid (fifo_valid),
        .o_data_ready (fifo_ready),
        .o_wdata      (o_wdata),
        .o_wlast      (o_wlast),
        .o_wvalid     (o_wvalid),
        .i_wready     (i_wready)
    );

    // one entry popped per B response
    dma_wr_fifo #(
        .payload_t  (len_t),
        .DEPTH_LOG2 (LEN_FIFO_DEPTH_LOG2)
    ) blen_fifo_i (
        .aclk    (aclk),
        .aresetn (aresetn),
        .i_data  (blen_in),
        .i_valid (blen_in_valid),
        .o_ready (blen_in_ready),
        .o_data  (blen_out),
        .o_valid (blen_out_valid),
        .i_ready (i_bvalid)
    );

    always_ff @(posedge aclk) begin
        if (!aresetn) begin
            o_complete_valid <= 1'b0;
        end else begin
            o_complete_valid <= i_bvalid && blen_out_valid;
        end
    end

    always_ff @(posedge aclk) begin
        if (i_bvalid) begin
            o_complete_size <= blen_out;
        end
    end

endmodule

/* tests/tb_dma_wr.sv */
// ----------------------------------------------------------
// testbench for the DMA write engine: stimulus, AXI slave
// model, ring and credit checker, watchdog
// ----------------------------------------------------------

`timescale 1ns/1ps

module tb_dma_wr import dma_wr_pkg::*; ();

    localparam int CLK_PERIOD   = 40;
    localparam int RESET_CYCLES = 16;

    logic                aclk;
    logic                aresetn;
    logic                i_enable;
    logic                o_busy;
    logic                i_update_param;
    addr_t               i_param_base;
    size_t               i_param_ring_size;
    len_t                i_param_max_len;
    logic [TMO_W-1:0]    i_param_timeout;
    logic [DATA_W/8-1:0] i_param_wstrb;
    beat_t               i_s_data;
    logic                i_s_valid;
    logic                o_s_ready;
    len_t                i_permit_size;
    logic                i_permit_valid;
    len_t                o_complete_size;
    logic                o_complete_valid;
    addr_t               o_awaddr;
    len_t                o_awlen;
    logic [2:0]          o_awsize;
    logic [1:0]          o_awburst;
    logic                o_awvalid;
    logic                i_awready;
    beat_t               o_wdata;
    logic [DATA_W/8-1:0] o_wstrb;
    logic                o_wlast;
    logic                o_wvalid;
    logic                i_wready;
    logic                i_bvalid;
    logic                o_bready;

    integer seed = 32'h2177_1418;
    int     err_value = 0;
    int     err_other = 0;
    int     cycle_cnt = 0;
    int     deadline = 2000;
    int     test_num = 0;

    // checker state, cleared per test
    addr_t               cfg_base;
    int                  cfg_ring;
    int                  cfg_max;
    logic [DATA_W/8-1:0] cfg_wstrb;
    int                  exp_offset;
    int                  issued;
    int                  permitted;
    int                  completed;
    int                  w_count;
    int                  w_in_burst;
    int                  w_bursts = 0;
    int                  b_sent = 0;
    logic                last_bvalid = 1'b0;
    len_t                aw_lens[$];
    len_t                b_lens[$];

    dma_wr_top dma_wr_top_i (.*);

    initial begin
        aclk = 1'b0;
        forever #(CLK_PERIOD / 2) aclk = ~aclk;
    end

    // ------------------------------------------------------------
    // helpers
    // ------------------------------------------------------------
    function automatic beat_t beat_value(input int t, input int i);
        return {t[7:0], i[23:0]} ^ 32'h3c5a_a5c3;
    endfunction

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        if (got !== exp) begin
            err_value++;
            $display("ERR %0t %s got %h expected %h", $time, name, got, exp);
        end
    endtask

    task automatic report_error(input string what);
        err_other++;
        $display("%0t error: %s", $time, what);
    endtask

    // ------------------------------------------------------------
    // AXI slave model and watchdog
    // ------------------------------------------------------------
    always @(posedge aclk) begin
        if (!aresetn) begin
            i_awready <= 1'b0;
            i_wready  <= 1'b0;
            i_bvalid  <= 1'b0;
        end else begin
            i_awready <= (($random(seed) & 3) != 0);
            i_wready  <= (($random(seed) & 3) != 0);
            // one B per burst closed by wlast
            if ((b_sent < w_bursts) && (($random(seed) & 1) != 0)) begin
                i_bvalid <= 1'b1;
                b_sent   <= b_sent + 1;
            end else begin
                i_bvalid <= 1'b0;
            end
        end
    end

    always @(posedge aclk) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt > deadline) begin
            report_error($sformatf("test %0d timed out, the DUT stopped making progress",
                                   test_num));
            $display("tests failed");
            $finish;
        end
    end

    // ------------------------------------------------------------
    // bus monitor, sampled mid-cycle
    // ------------------------------------------------------------
    always @(negedge aclk) begin
        if (aresetn) begin
            if (o_awvalid && i_awready) begin
                check_value("o_awaddr", o_awaddr, cfg_base + addr_t'(exp_offset * BEAT_BYTES));
                check_value("o_awsize", 32'(o_awsize), 32'd2);
                check_value("o_awburst", 32'(o_awburst), 32'd1);
                if (int'(o_awlen) > cfg_max) begin
                    report_error("burst longer than max length plus one");
                end
                if (exp_offset + int'(o_awlen) + 1 > cfg_ring) begin
                    report_error("burst crosses the end of the ring");
                end
                issued = issued + int'(o_awlen) + 1;
                if (issued > cfg_ring + permitted) begin
                    report_error($sformatf("%0d beats issued with only %0d allowed",
                                           issued, cfg_ring + permitted));
                end
                exp_offset = (exp_offset + int'(o_awlen) + 1) % cfg_ring;
                aw_lens.push_back(o_awlen);
                b_lens.push_back(o_awlen);
            end
            if (o_wvalid && i_wready) begin
                check_value("o_wdata", o_wdata, beat_value(test_num, w_count));
                check_value("o_wstrb", 32'(o_wstrb), 32'(cfg_wstrb));
                if (aw_lens.size() == 0) begin
                    report_error("W beat arrived with no AW burst open");
                end else begin
                    check_value("o_wlast", 32'(o_wlast), 32'(w_in_burst == int'(aw_lens[0])));
                    if (w_in_burst == int'(aw_lens[0])) begin
                        void'(aw_lens.pop_front());
                        w_in_burst = 0;
                    end else begin
                        w_in_burst++;
                    end
                end
                if (o_wlast) begin
                    w_bursts++;
                end
                w_count++;
            end
            if (i_bvalid) begin
                check_value("o_bready", 32'(o_bready), 32'd1);
            end
            // completion one cycle after each B
            check_value("o_complete_valid", 32'(o_complete_valid), 32'(last_bvalid));
            if (o_complete_valid) begin
                if (b_lens.size() == 0) begin
                    report_error("completion with no burst outstanding");
                end else begin
                    check_value("o_complete_size", 32'(o_complete_size), 32'(b_lens.pop_front()));
                end
                completed = completed + int'(o_complete_size) + 1;
            end
        end
        last_bvalid = i_bvalid;
    end

    // ------------------------------------------------------------
    // stimulus
    // ------------------------------------------------------------
    task automatic drive_beats(input int beats);
        int i;
        for (i = 0; i < beats; i++) begin
            if (($random(seed) & 7) == 0) begin
                i_s_valid <= 1'b0;
                @(posedge aclk);
            end
            i_s_data  <= beat_value(test_num, i);
            i_s_valid <= 1'b1;
            @(negedge aclk);
            while (!o_s_ready) @(negedge aclk);
            @(posedge aclk);
        end
        i_s_valid <= 1'b0;
    endtask

    // reader side, returns credit for completed beats
    task automatic send_permits(input int beats, input int ring, input int interval);
        int first;
        int size;
        int released;
        first    = (beats < ring) ? beats : ring;
        released = 0;
        while (completed < first) @(posedge aclk);
        repeat (interval + 1) @(posedge aclk);
        // credit used up, AW must have stopped here
        check_value("issued beats", issued, first);
        while (released < beats) begin
            if (completed > released) begin
                size = completed - released;
                if (size > 256) begin
                    size = 256;
                end
                i_permit_size  <= len_t'(size - 1);
                i_permit_valid <= 1'b1;
                permitted = permitted + size;
                released  = released + size;
                @(posedge aclk);
                i_permit_valid <= 1'b0;
            end
            repeat (interval + 1) @(posedge aclk);
        end
    endtask

    task automatic run_test(input addr_t base, input int ring, input int max_len,
                            input int tmo, input logic [DATA_W/8-1:0] strb,
                            input int beats, input int interval);
        int wait_cnt;
        test_num++;
        deadline   = cycle_cnt + beats * 200 + interval * 16 + 2000;
        cfg_base   = base;
        cfg_ring   = ring;
        cfg_max    = max_len;
        cfg_wstrb  = strb;
        exp_offset = 0;
        issued     = 0;
        permitted  = 0;
        completed  = 0;
        w_count    = 0;
        w_in_burst = 0;
        wait_cnt   = 0;
        aw_lens.delete();
        b_lens.delete();
        i_param_base      <= base;
        i_param_ring_size <= size_t'(ring);
        i_param_max_len   <= len_t'(max_len);
        i_param_timeout   <= TMO_W'(tmo);
        i_param_wstrb     <= strb;
        i_update_param    <= 1'b1;
        @(posedge aclk);
        i_update_param <= 1'b0;
        repeat (3) @(posedge aclk);
        i_enable <= 1'b1;
        fork
            drive_beats(beats);
            send_permits(beats, ring, interval);
        join
        i_enable <= 1'b0;
        repeat (2) @(negedge aclk);
        while (o_busy && wait_cnt < 8) begin
            @(negedge aclk);
            wait_cnt++;
        end
        if (o_busy) begin
            report_error("o_busy stayed high after enable dropped and all bursts completed");
        end
        check_value("W beat count", w_count, beats);
        check_value("completed beats", completed, beats);
        if (aw_lens.size() != 0 || b_lens.size() != 0) begin
            report_error("bursts left open at the end of the test");
        end
        @(posedge aclk);
    endtask

    // ------------------------------------------------------------
    // main sequence
    // ------------------------------------------------------------
    initial begin
        int                  fd;
        string               line;
        addr_t               base;
        int                  ring;
        int                  max_len;
        int                  tmo;
        logic [DATA_W/8-1:0] strb;
        int                  beats;
        int                  interval;
        aresetn           <= 1'b0;
        i_enable          <= 1'b0;
        i_update_param    <= 1'b0;
        i_param_base      <= '0;
        i_param_ring_size <= '0;
        i_param_max_len   <= '0;
        i_param_timeout   <= '0;
        i_param_wstrb     <= '0;
        i_s_data          <= '0;
        i_s_valid         <= 1'b0;
        i_permit_size     <= '0;
        i_permit_valid    <= 1'b0;
        i_awready         <= 1'b0;
        i_wready          <= 1'b0;
        i_bvalid          <= 1'b0;
        repeat (RESET_CYCLES - 1) @(posedge aclk);
        @(negedge aclk);
        check_value("o_s_ready", 32'(o_s_ready), 32'd0);
        check_value("o_awvalid", 32'(o_awvalid), 32'd0);
        check_value("o_wvalid", 32'(o_wvalid), 32'd0);
        check_value("o_complete_valid", 32'(o_complete_valid), 32'd0);
        check_value("o_busy", 32'(o_busy), 32'd0);
        @(posedge aclk);
        aresetn <= 1'b1;
        repeat (4) @(posedge aclk);

        fd = $fopen("tests/dma_wr_testdata.txt", "r");
        if (fd == 0) begin
            report_error("could not open tests/dma_wr_testdata.txt");
        end else begin
            while ($fgets(line, fd) != 0) begin
                if (line.len() > 1 && line[0] != "#" &&
                    $sscanf(line, "%h %d %d %d %h %d %d", base, ring, max_len, tmo, strb,
                            beats, interval) == 7) begin
                    run_test(base, ring, max_len, tmo, strb, beats, interval);
                end
            end
            $fclose(fd);
            if (test_num == 0) begin
                report_error("no test lines found in the data file");
            end
        end

        $display("tests run %0d, value errors %0d, other errors %0d",
                 test_num, err_value, err_other);
        if (err_value + err_other == 0) begin
            $display("all tests passed");
        end else begin
            $display("tests failed");
        end
        $finish;
    end

endmodule

/* tests/dma_wr_testdata.txt */
# base ring_size max_len timeout wstrb beats permit_interval
# base and wstrb in hex, the other columns in decimal
00001000 64 15 8 f 200 20
00002000 100 7 4 f 250 10
00003000 256 255 16 f 600 30
00010000 48 15 20 3 10 5
00020000 32 31 2 c 400 300
00004000 1 0 0 f 20 3
00005000 37 9 1 5 333 7
00006000 1024 63 50 f 5 4
00007000 16 3 6 f 90 0

/* dma_wr.f */
hdl/dma_wr_pkg.sv
hdl/dma_wr_cmd_if.sv
hdl/dma_wr_fifo.sv
hdl/dma_wr_regs.sv
hdl/dma_wr_burst_ctrl.sv
hdl/dma_wr_addr_gen.sv
hdl/dma_wr_beat_gate.sv
hdl/dma_wr_top.sv
tests/tb_dma_wr.sv

/* run_sim.sh */
#!/bin/sh
# build and run the DMA write engine testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
    --top-module tb_dma_wr -f dma_wr.f -Mdir obj_dir
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

./obj_dir/Vtb_dma_wr > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "^tests failed$" sim.log; then
    exit 1
fi
exit 0
